//--- zhxpu_pkg.sv
package zhxpu_pkg;

	localparam int WORD_W = 16;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [2:0] shamt_t;

	// primary opcodes, inst[15:11]
	localparam logic [4:0] OPC_NOP = 5'b00001;
	localparam logic [4:0] OPC_B = 5'b00010;
	localparam logic [4:0] OPC_BEQZ = 5'b00100;
	localparam logic [4:0] OPC_BNEZ = 5'b00101;
	localparam logic [4:0] OPC_SLL = 5'b00110;
	localparam logic [4:0] OPC_ADDIU = 5'b01001;
	localparam logic [4:0] OPC_LI = 5'b01101;
	localparam logic [4:0] OPC_RRR = 5'b11100;
	localparam logic [4:0] OPC_RR = 5'b11101;

	// three-register group, inst[1:0]
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;
	// shift group, inst[1:0]
	localparam logic [1:0] FN_SLL = 2'b00;
	// two-register group, inst[4:0]
	localparam logic [4:0] FN_SLT = 5'b00010;
	localparam logic [4:0] FN_AND = 5'b01100;
	localparam logic [4:0] FN_OR = 5'b01101;

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LI,
		OP_ADDIU,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_SLT,
		OP_SLL,
		OP_B,
		OP_BEQZ,
		OP_BNEZ
	} op_t;

	typedef struct packed {
		op_t op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic uses_rs1;
		logic uses_rs2;
		reg_addr_t rd;
		logic reg_write;
		word_t imm;
	} decoded_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		op_t op;
		reg_addr_t rd;
		logic reg_write;
		word_t a;
		// rs2 value or immediate, picked in ID
		word_t b;
		shamt_t shamt;
	} id_exe_t;

	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		logic reg_write;
		word_t result;
	} exe_wb_t;

	typedef struct packed {
		logic valid;
		reg_addr_t addr;
		word_t value;
	} wb_port_t;

	// empty slots, invalid and NOP
	localparam if_id_t IF_ID_BUBBLE = '0;
	localparam id_exe_t ID_EXE_BUBBLE = '0;
	localparam exe_wb_t EXE_WB_BUBBLE = '0;

endpackage

//--- pc_reg.sv
`timescale 1ns/1ps

module pc_reg #(
	parameter zhxpu_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic taken,
	input zhxpu_pkg::word_t target,
	output zhxpu_pkg::word_t pc
);

	// taken arrives already gated by hold
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (taken) begin
			pc <= target;
		end else if (!hold) begin
			// word addressed, next instruction is pc + 1
			pc <= pc + 16'd1;
		end
	end

endmodule

//--- stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic,
	parameter payload_t BUBBLE = '0
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// flush beats hold
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= BUBBLE;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
	input zhxpu_pkg::word_t inst,
	input logic valid,
	output zhxpu_pkg::decoded_t dec
);
	import zhxpu_pkg::*;

	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t imm_s8;
	word_t imm_z8;
	word_t imm_s11;
	word_t imm_sh;

	assign rx = inst[10:8];
	assign ry = inst[7:5];
	assign rz = inst[4:2];

	assign imm_s8 = {{8{inst[7]}}, inst[7:0]};
	assign imm_z8 = {8'b0, inst[7:0]};
	assign imm_s11 = {{5{inst[10]}}, inst[10:0]};
	// raw 3-bit amount, 0 is turned into 8 in the ALU
	assign imm_sh = {13'b0, inst[4:2]};

	always_comb begin
		// empty slot or unknown encoding stays NOP with no flags
		dec = '0;
		if (valid) begin
			case (inst[15:11])
				OPC_NOP: begin
					dec.op = OP_NOP;
				end
				OPC_LI: begin
					dec = '{op: OP_LI, rs1: '0, rs2: '0, uses_rs1: 1'b0, uses_rs2: 1'b0,
						rd: rx, reg_write: 1'b1, imm: imm_z8};
				end
				OPC_ADDIU: begin
					dec = '{op: OP_ADDIU, rs1: rx, rs2: '0, uses_rs1: 1'b1, uses_rs2: 1'b0,
						rd: rx, reg_write: 1'b1, imm: imm_s8};
				end
				OPC_RRR: begin
					if (inst[1:0] == FN_ADDU || inst[1:0] == FN_SUBU) begin
						dec = '{op: (inst[1:0] == FN_ADDU) ? OP_ADDU : OP_SUBU,
							rs1: rx, rs2: ry, uses_rs1: 1'b1, uses_rs2: 1'b1,
							rd: rz, reg_write: 1'b1, imm: '0};
					end
				end
				OPC_RR: begin
					// result goes back to rx
					case (inst[4:0])
						FN_AND: dec.op = OP_AND;
						FN_OR: dec.op = OP_OR;
						FN_SLT: dec.op = OP_SLT;
						default: dec.op = OP_NOP;
					endcase
					if (dec.op != OP_NOP) begin
						dec.rs1 = rx;
						dec.rs2 = ry;
						dec.uses_rs1 = 1'b1;
						dec.uses_rs2 = 1'b1;
						dec.rd = rx;
						dec.reg_write = 1'b1;
					end
				end
				OPC_SLL: begin
					if (inst[1:0] == FN_SLL) begin
						dec = '{op: OP_SLL, rs1: '0, rs2: ry, uses_rs1: 1'b0, uses_rs2: 1'b1,
							rd: rx, reg_write: 1'b1, imm: imm_sh};
					end
				end
				OPC_B: begin
					dec.op = OP_B;
					dec.imm = imm_s11;
				end
				OPC_BEQZ, OPC_BNEZ: begin
					dec.op = (inst[11]) ? OP_BNEZ : OP_BEQZ;
					dec.rs1 = rx;
					dec.uses_rs1 = 1'b1;
					dec.imm = imm_s8;
				end
				default: begin
					dec.op = OP_NOP;
				end
			endcase
		end
	end

endmodule

//--- jmp_ctrl.sv
`timescale 1ns/1ps

module jmp_ctrl (
	input zhxpu_pkg::decoded_t dec,
	input zhxpu_pkg::word_t pc,
	input zhxpu_pkg::word_t rx_value,
	input logic hold,
	output logic taken,
	output zhxpu_pkg::word_t target
);
	import zhxpu_pkg::*;

	logic cond;

	always_comb begin
		case (dec.op)
			OP_B: cond = 1'b1;
			OP_BEQZ: cond = (rx_value == '0);
			OP_BNEZ: cond = (rx_value != '0);
			default: cond = 1'b0;
		endcase
	end

	// rx may still be in flight while stalled, so no redirect then
	assign taken = cond && !hold;

	// offset counts from the slot after the branch
	assign target = pc + 16'd1 + dec.imm;

endmodule

//--- register.sv
`timescale 1ns/1ps

module register (
	input logic clk,
	input logic reset,
	input zhxpu_pkg::reg_addr_t rs1,
	input zhxpu_pkg::reg_addr_t rs2,
	output zhxpu_pkg::word_t value1,
	output zhxpu_pkg::word_t value2,
	input zhxpu_pkg::wb_port_t wr
);
	import zhxpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid) begin
			regs[wr.addr] <= wr.value;
		end
	end

	// same-cycle write is seen by ID
	assign value1 = (wr.valid && wr.addr == rs1) ? wr.value : regs[rs1];
	assign value2 = (wr.valid && wr.addr == rs2) ? wr.value : regs[rs2];

endmodule

//--- stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl (
	input zhxpu_pkg::decoded_t dec,
	input zhxpu_pkg::reg_addr_t exe_rd,
	input logic exe_writes,
	output logic hold
);

	logic hit1;
	logic hit2;

	// only EXE can conflict, WB is covered by write-through
	assign hit1 = dec.uses_rs1 && (dec.rs1 == exe_rd);
	assign hit2 = dec.uses_rs2 && (dec.rs2 == exe_rd);

	assign hold = exe_writes && (hit1 || hit2);

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input zhxpu_pkg::op_t op,
	input zhxpu_pkg::word_t a,
	input zhxpu_pkg::word_t b,
	input zhxpu_pkg::shamt_t shamt,
	output zhxpu_pkg::word_t result
);
	import zhxpu_pkg::*;

	logic [3:0] shift_by;

	// encoded 0 shifts by 8
	assign shift_by = (shamt == 3'd0) ? 4'd8 : {1'b0, shamt};

	always_comb begin
		case (op)
			OP_ADDU, OP_ADDIU: result = a + b;
			OP_SUBU: result = a - b;
			OP_AND: result = a & b;
			OP_OR: result = a | b;
			OP_SLT: result = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			OP_SLL: result = b << shift_by;
			// immediate already sits on b
			OP_LI: result = b;
			default: result = '0;
		endcase
	end

endmodule

//--- zhxpu.sv
`timescale 1ns/1ps

module zhxpu #(
	parameter zhxpu_pkg::word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output zhxpu_pkg::word_t imem_addr,
	input zhxpu_pkg::word_t imem_data,
	output zhxpu_pkg::wb_port_t wb
);
	import zhxpu_pkg::*;

	word_t pc;
	word_t target;
	logic hold;
	logic taken;

	if_id_t if_id_d;
	if_id_t if_id_q;
	id_exe_t id_exe_d;
	id_exe_t id_exe_q;
	exe_wb_t exe_wb_d;
	exe_wb_t exe_wb_q;

	decoded_t dec;
	word_t value1;
	word_t value2;
	word_t alu_result;

	// IF
	pc_reg #(.RESET_PC(RESET_PC)) u_pc_reg (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.taken(taken),
		.target(target),
		.pc(pc)
	);

	assign imem_addr = pc;
	assign if_id_d = '{valid: 1'b1, pc: pc, inst: imem_data};

	// wrong-path fetch is dropped on a taken branch
	stage_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) u_if_id (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.flush(taken),
		.d(if_id_d),
		.q(if_id_q)
	);

	// ID
	decoder u_decoder (
		.inst(if_id_q.inst),
		.valid(if_id_q.valid),
		.dec(dec)
	);

	register u_register (
		.clk(clk),
		.reset(reset),
		.rs1(dec.rs1),
		.rs2(dec.rs2),
		.value1(value1),
		.value2(value2),
		.wr(wb)
	);

	stall_ctrl u_stall_ctrl (
		.dec(dec),
		.exe_rd(id_exe_q.rd),
		.exe_writes(id_exe_q.valid && id_exe_q.reg_write),
		.hold(hold)
	);

	jmp_ctrl u_jmp_ctrl (
		.dec(dec),
		.pc(if_id_q.pc),
		.rx_value(value1),
		.hold(hold),
		.taken(taken),
		.target(target)
	);

	always_comb begin
		id_exe_d.valid = if_id_q.valid;
		id_exe_d.op = dec.op;
		id_exe_d.rd = dec.rd;
		id_exe_d.reg_write = dec.reg_write;
		id_exe_d.a = value1;
		id_exe_d.b = dec.uses_rs2 ? value2 : dec.imm;
		id_exe_d.shamt = dec.imm[2:0];
	end

	// a stalled instruction stays in ID, EXE gets a bubble
	stage_reg #(.payload_t(id_exe_t), .BUBBLE(ID_EXE_BUBBLE)) u_id_exe (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(hold),
		.d(id_exe_d),
		.q(id_exe_q)
	);

	// EXE
	alu u_alu (
		.op(id_exe_q.op),
		.a(id_exe_q.a),
		.b(id_exe_q.b),
		.shamt(id_exe_q.shamt),
		.result(alu_result)
	);

	assign exe_wb_d = '{
		valid: id_exe_q.valid,
		rd: id_exe_q.rd,
		reg_write: id_exe_q.reg_write,
		result: alu_result
	};

	stage_reg #(.payload_t(exe_wb_t), .BUBBLE(EXE_WB_BUBBLE)) u_exe_wb (
		.clk(clk),
		.reset(reset),
		.hold(1'b0),
		.flush(1'b0),
		.d(exe_wb_d),
		.q(exe_wb_q)
	);

	// WB
	assign wb.valid = exe_wb_q.valid && exe_wb_q.reg_write;
	assign wb.addr = exe_wb_q.rd;
	assign wb.value = exe_wb_q.result;

endmodule

//--- zhxpu_chk.sv
`timescale 1ns/1ps

module zhxpu_chk (
	input logic clk,
	input logic reset,
	input zhxpu_pkg::word_t pc,
	input zhxpu_pkg::word_t imem_addr,
	input logic hold,
	input logic taken,
	input zhxpu_pkg::wb_port_t wb
);

	// all stages are bubbles right after reset
	a_wb_idle: assert property (@(posedge clk) reset |=> !wb.valid)
		else $error("wb valid in the cycle after reset");

	a_pc_hold: assert property (@(posedge clk) disable iff (reset) hold |=> $stable(pc))
		else $error("pc moved while hold was high");

	// a stall lasts one cycle and a squashed slot never stalls
	a_hold_once: assert property (@(posedge clk) disable iff (reset) (taken || hold) |=> !hold)
		else $error("hold high right after a stall or a redirect");

	a_addr_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(imem_addr))
		else $error("imem_addr has unknown bits");

endmodule

bind zhxpu zhxpu_chk u_chk (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.imem_addr(imem_addr),
	.hold(hold),
	.taken(taken),
	.wb(wb)
);

//--- tb_zhxpu.sv
`timescale 1ns/1ps

module tb_zhxpu;
	import zhxpu_pkg::*;

	localparam word_t PROG_END = 16'd200;
	localparam int PROG_LEN = 200;
	localparam int TIMEOUT_CYCLES = 3 * PROG_LEN + 50;

	logic clk = 1'b0;
	logic reset;
	word_t imem_addr;
	word_t imem_data;
	wb_port_t wb;

	word_t imem [256];
	word_t model_regs [8];
	word_t model_end_pc;
	wb_port_t exp_q [$];
	logic [31:0] lcg_state;
	int wr_count = 0;
	int cycle_count = 0;

	zhxpu #(.RESET_PC(16'd0)) i_dut (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb(wb)
	);

	always #5 clk = ~clk;

	// past the array the fetch still sees a NOP
	assign imem_data = (imem_addr < 16'd256) ? imem[imem_addr[7:0]] : {OPC_NOP, imem_addr[10:0]};

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic abort_run(input string why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic gen_program();
		logic [15:0] r;
		int kind;
		for (int i = 0; i < 256; i++) begin
			r = next_rand();
			kind = int'(next_rand() % 16'd12);
			if (i >= PROG_LEN) begin
				imem[i] = {OPC_NOP, i[10:0]};
			end else begin
				// branch offsets stay in 0..7, always forward
				case (kind)
					0: imem[i] = {OPC_NOP, 11'd0};
					1: imem[i] = {OPC_LI, r[2:0], r[15:8]};
					2: imem[i] = {OPC_ADDIU, r[2:0], r[15:8]};
					3: imem[i] = {OPC_RRR, r[2:0], r[5:3], r[8:6], FN_ADDU};
					4: imem[i] = {OPC_RRR, r[2:0], r[5:3], r[8:6], FN_SUBU};
					5: imem[i] = {OPC_RR, r[2:0], r[5:3], FN_AND};
					6: imem[i] = {OPC_RR, r[2:0], r[5:3], FN_OR};
					7: imem[i] = {OPC_RR, r[2:0], r[5:3], FN_SLT};
					8: imem[i] = {OPC_SLL, r[2:0], r[5:3], r[8:6], FN_SLL};
					9: imem[i] = {OPC_B, 8'd0, r[11:9]};
					10: imem[i] = {r[12] ? OPC_BNEZ : OPC_BEQZ, r[2:0], 5'd0, r[11:9]};
					// opcode 11111 is not part of the ISA
					default: imem[i] = {5'b11111, r[15:8], r[8:6]};
				endcase
			end
		end
	endtask

	task automatic record_write(input reg_addr_t addr, input word_t value);
		model_regs[addr] = value;
		exp_q.push_back('{valid: 1'b1, addr: addr, value: value});
	endtask

	// architectural model, one instruction per step, no pipeline
	task automatic run_model();
		word_t pc;
		word_t inst;
		word_t a;
		word_t b;
		word_t sext8;
		logic [3:0] sa;
		for (int k = 0; k < 8; k++) begin
			model_regs[k] = '0;
		end
		pc = '0;
		while (pc < PROG_END) begin
			inst = imem[pc[7:0]];
			a = model_regs[inst[10:8]];
			b = model_regs[inst[7:5]];
			sext8 = {{8{inst[7]}}, inst[7:0]};
			sa = (inst[4:2] == 3'd0) ? 4'd8 : {1'b0, inst[4:2]};
			pc = pc + 16'd1;
			case (inst[15:11])
				OPC_LI: record_write(inst[10:8], {8'd0, inst[7:0]});
				OPC_ADDIU: record_write(inst[10:8], a + sext8);
				OPC_RRR: begin
					if (inst[1:0] == FN_ADDU) begin
						record_write(inst[4:2], a + b);
					end else if (inst[1:0] == FN_SUBU) begin
						record_write(inst[4:2], a - b);
					end
				end
				OPC_RR: begin
					if (inst[4:0] == FN_AND) begin
						record_write(inst[10:8], a & b);
					end else if (inst[4:0] == FN_OR) begin
						record_write(inst[10:8], a | b);
					end else if (inst[4:0] == FN_SLT) begin
						record_write(inst[10:8], ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
					end
				end
				OPC_SLL: begin
					if (inst[1:0] == FN_SLL) begin
						record_write(inst[10:8], b << sa);
					end
				end
				OPC_B: pc = pc + {{5{inst[10]}}, inst[10:0]};
				OPC_BEQZ: pc = (a == '0) ? pc + sext8 : pc;
				OPC_BNEZ: pc = (a != '0) ? pc + sext8 : pc;
				default: ;
			endcase
		end
		model_end_pc = pc;
	endtask

	task automatic check_wb(input wb_port_t got, input wb_port_t exp);
		if (got !== exp) begin
			$display("ERROR: %0t wb got valid=%b addr=%0d value=%h, expected valid=%b addr=%0d value=%h",
				$time, got.valid, got.addr, got.value, exp.valid, exp.addr, exp.value);
			abort_run("register write mismatch");
		end
	endtask

	task automatic check_pc_range(input string name, input word_t got, input word_t lo,
		input word_t hi);
		if ($isunknown(got) || got < lo || got > hi) begin
			$display("ERROR: %0t %s got %h, expected %h to %h", $time, name, got, lo, hi);
			abort_run("final fetch address out of range");
		end
	endtask

	task automatic take_write();
		if (wb.valid !== 1'b0) begin
			if (wr_count >= exp_q.size()) begin
				$display("register write to r%0d beyond the %0d writes of the program",
					wb.addr, exp_q.size());
				abort_run("extra register write");
			end else begin
				check_wb(wb, exp_q[wr_count]);
				wr_count++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				$display("timeout, program end not reached in %0d cycles", TIMEOUT_CYCLES);
				abort_run("timeout");
			end
		end
	end

	initial begin
		logic past_end;
		int drain;
		reset = 1'b1;
		lcg_state = 32'd54;
		past_end = 1'b0;
		drain = 0;
		gen_program();
		run_model();
		$display("program expects %0d register writes", exp_q.size());
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// one extra drain cycle covers a stall of the last instruction
		while (drain < 4) begin
			@(negedge clk);
			take_write();
			if (past_end) begin
				drain++;
			end else if (imem_addr >= PROG_END) begin
				past_end = 1'b1;
			end
		end
		check_pc_range("imem_addr", imem_addr, model_end_pc, model_end_pc + 16'd4);
		if (wr_count != exp_q.size()) begin
			$display("only %0d of %0d register writes retired", wr_count, exp_q.size());
			abort_run("missing register writes");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- project.f
zhxpu_pkg.sv
pc_reg.sv
stage_reg.sv
decoder.sv
jmp_ctrl.sv
register.sv
stall_ctrl.sv
alu.sv
zhxpu.sv
zhxpu_chk.sv
tb_zhxpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_zhxpu -f project.f -o tb_zhxpu \
	&& ./obj_dir/tb_zhxpu \
	|| exit 1
